// File: compile.f
source/scTimingPkg.sv
source/scWordPkg.sv
source/scEtuBusIf.sv
source/scBitTimer.sv
source/scDataShifter.sv
source/scFrameChecker.sv
source/scCharWriter.sv
source/scReceiver.sv
test/scReceiver_sva.sv
test/scRxChecker.sv
test/tbScReceiver.sv

// File: test/tbScReceiver.sv
// ********************
// Smartcard receiver testbench
// LCG-chosen T=0 frames on ScIo, Ignore windows,
// random Wishbone ACK delays and forced overruns
// ********************
`default_nettype none

module tbScReceiver import scWordPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED        = 32'h4db9_5a74;
  localparam int          BIT_CLKS    = 12;    // 4 ticks of 3 clocks
  localparam int          NUM_FRAMES  = 60;
  localparam int          STB_LIMIT   = 5000;  // Longest quiet bus
  localparam int          HOLD_LIMIT  = 2000;
  localparam int          DRAIN_LIMIT = 1000;
  // Frame kinds
  localparam int K_CLEAN   = 0;
  localparam int K_PARITY  = 1;
  localparam int K_GUARD   = 2;
  localparam int K_BOTH    = 3;
  localparam int K_GLITCH  = 4;
  localparam int K_IGNORED = 5;

  logic        CLK_I;
  logic        RST_I;
  logic        ScIo;
  logic        Ignore;
  logic        CYC_O;
  logic        STB_O;
  logic        ACK_I;
  rxWord       DAT_O;
  logic [31:0] stimState;
  logic [31:0] ackState;
  logic        holdAck;         // Keeps the pending word unacknowledged
  logic        runDone;
  logic        pendingOverrun;  // Next expected word carries overrun
  int          timeoutCount;
  int          totalErrors;

  always #10 CLK_I = ~CLK_I;

  scReceiver u_scReceiver (
    .CLK_I  (CLK_I),
    .RST_I  (RST_I),
    .ScIo   (ScIo),
    .Ignore (Ignore),
    .CYC_O  (CYC_O),
    .STB_O  (STB_O),
    .ACK_I  (ACK_I),
    .DAT_O  (DAT_O)
  );

  scRxChecker u_check (
    .CLK_I (CLK_I),
    .RST_I (RST_I),
    .CYC_O (CYC_O),
    .STB_O (STB_O),
    .ACK_I (ACK_I),
    .DAT_O (DAT_O)
  );

  // ********************
  // Random streams
  // ********************
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned stimRand();
    stimState = lcgNext(stimState);
    return {8'h00, stimState[31:8]};  // Upper bits, better period
  endfunction

  function automatic int unsigned ackRand();
    ackState = lcgNext(ackState);
    return {8'h00, ackState[31:8]};
  endfunction

  // Always returns 2 ns after a rising edge
  task automatic holdLine(input int n);
    if (n > 0)
    begin
      repeat (n) @(posedge CLK_I);
      #2;
    end
  endtask

  task automatic sendFrame(input logic [7:0] data, input int kind, input int gap);
    logic [10:0] bits;
    logic        parityBit;
    parityBit = ^data ^ (kind == K_PARITY || kind == K_BOTH);       // Even parity unless flipped
    bits      = {!(kind == K_GUARD || kind == K_BOTH), parityBit, data, 1'b0};
    if (kind == K_GLITCH)
    begin
      ScIo = 1'b0;
      holdLine(4);  // Under half a bit
      ScIo = 1'b1;
      holdLine(gap);
    end
    else
    begin
      Ignore = (kind == K_IGNORED);  // Covers the whole frame
      for (int b = 0; b < 11; b++)
      begin
        ScIo = bits[b];  // LSB first, start bit at index 0
        holdLine(BIT_CLKS);
      end
      ScIo = 1'b1;
      holdLine(6);     // Past the synchronizer
      Ignore = 1'b0;
      holdLine(gap - 6);
    end
  endtask

  // Expected word from the frame kind
  task automatic expectFrame(input logic [7:0] data, input int kind);
    rxErrCode code;
    case (kind)
      K_PARITY: code = ERR_PARITY;
      K_GUARD:  code = ERR_GUARD;
      K_BOTH:   code = ERR_PARITY_GUARD;
      K_GLITCH: code = ERR_FALSE_START;
      default:  code = ERR_NONE;
    endcase
    if (kind != K_IGNORED)
    begin
      u_check.expectWord((kind == K_GLITCH) ? 8'h00 : data, code, pendingOverrun);
      pendingOverrun = 1'b0;
    end
  endtask

  // ********************
  // Frame sequence
  // ********************
  task automatic runFrames();
    logic [7:0] data;
    int         kind;
    int         sel;
    int         gap;
    logic       forceOverrun;
    int         waitCnt;
    for (int i = 0; i < NUM_FRAMES && timeoutCount == 0; i++)
    begin
      data = 8'(stimRand() % 256);
      sel  = stimRand() % 16;
      gap  = 24 + stimRand() % 40;
      case (sel)
        8, 9:    kind = K_PARITY;
        10:      kind = K_GUARD;
        11:      kind = K_BOTH;
        12:      kind = K_GLITCH;
        13:      kind = K_IGNORED;
        default: kind = K_CLEAN;
      endcase
      if (i < 6)
        kind = i;  // Every kind early in the run
      forceOverrun = (kind != K_IGNORED) && (i == 2 || stimRand() % 8 == 0);
      // A glitch word is ready within a bit, so the bus must be free
      if (forceOverrun || kind == K_GLITCH)
      begin
        waitCnt = 0;
        while (STB_O && waitCnt < 200)  // Previous word out first
        begin
          holdLine(1);
          waitCnt++;
        end
        if (STB_O)
        begin
          timeoutCount++;
          $display("Timeout at %0t, previous word was never acknowledged", $time);
        end
      end
      if (forceOverrun)
        holdAck = 1'b1;
      expectFrame(data, kind);
      sendFrame(data, kind, gap);
      if (forceOverrun)
      begin
        sendFrame(8'(stimRand() % 256), K_CLEAN, 30);  // Dropped by the DUT
        pendingOverrun = 1'b1;
        holdAck        = 1'b0;
      end
    end
  endtask

  // Wishbone slave side
  task automatic ackLoop();
    int waitCnt;
    while (!runDone && timeoutCount == 0)
    begin
      waitCnt = 0;
      while (STB_O !== 1'b1 && !runDone && waitCnt < STB_LIMIT)
      begin
        holdLine(1);
        waitCnt++;
      end
      if (STB_O === 1'b1)
      begin
        waitCnt = 0;
        while (holdAck && waitCnt < HOLD_LIMIT)
        begin
          holdLine(1);
          waitCnt++;
        end
        if (holdAck)
        begin
          timeoutCount++;
          $display("Timeout at %0t, ACK hold was never released", $time);
        end
        holdLine(ackRand() % 41);
        ACK_I = 1'b1;  // One-clock acknowledge
        holdLine(1);
        ACK_I = 1'b0;
      end
      else if (!runDone)
      begin
        timeoutCount++;
        $display("Timeout at %0t, no Wishbone cycle within %0d clocks", $time, STB_LIMIT);
      end
    end
  endtask

  initial
  begin
    int waitCnt;
    CLK_I          = 1'b0;
    RST_I          = 1'b1;
    ScIo           = 1'b1;  // Idle line is high
    Ignore         = 1'b0;
    ACK_I          = 1'b0;
    stimState      = SEED;
    ackState       = SEED ^ 32'h5555_5555;  // Separate stream for ACK delays
    holdAck        = 1'b0;
    runDone        = 1'b0;
    pendingOverrun = 1'b0;
    timeoutCount   = 0;
    holdLine(10);
    RST_I = 1'b0;
    holdLine(20);
    fork
      ackLoop();
      begin
        runFrames();
        waitCnt = 0;
        while ((u_check.pendingWords() != 0 || STB_O) && waitCnt < DRAIN_LIMIT)
        begin
          holdLine(1);
          waitCnt++;
        end
        if (STB_O)
        begin
          timeoutCount++;
          $display("Timeout at %0t, Wishbone port did not drain", $time);
        end
        runDone = 1'b1;
      end
    join
    u_check.reportMissing();
    totalErrors = u_check.mismatchCount + u_check.unexpectedCount + u_check.missingCount +
                  u_scReceiver.u_sva.failCount + timeoutCount;
    $display("Words %0d, mismatches %0d, unexpected %0d, missing %0d, assertions %0d, timeouts %0d",
             u_check.wordCount, u_check.mismatchCount, u_check.unexpectedCount,
             u_check.missingCount, u_scReceiver.u_sva.failCount, timeoutCount);
    if (totalErrors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/scRxChecker.sv
// ********************
// Receive word monitor
// Queue of expected frames, compared on each acknowledged
// Wishbone cycle through both views of the status word
// ********************
`default_nettype none

module scRxChecker import scWordPkg::*; (
  input logic  CLK_I,
  input logic  RST_I,
  input logic  CYC_O,
  input logic  STB_O,
  input logic  ACK_I,
  input rxWord DAT_O
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [7:0] data;
    rxErrCode   code;
    logic       overrun;   // Earlier frame dropped
  } expFrame;

  expFrame expQ[$];        // Filled by the stimulus side
  int mismatchCount   = 0;
  int unexpectedCount = 0;
  int missingCount    = 0;
  int wordCount       = 0;

  task automatic expectWord(input logic [7:0] data, input rxErrCode code, input logic overrun);
    expQ.push_back('{data, code, overrun});
  endtask

  function automatic int pendingWords();
    return expQ.size();
  endfunction

  task automatic checkField(input string name, input logic [7:0] expV, input logic [7:0] gotV);
    if (gotV !== expV)
    begin
      mismatchCount++;
      $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, expV, gotV);
    end
  endtask

  // ********************
  // Word compare
  // ********************
  task automatic checkWord();
    expFrame exp;
    logic    expKind;
    wordCount++;
    if (expQ.size() == 0)
    begin
      unexpectedCount++;
      $display("Word %h arrived at time %0t while no frame was expected", DAT_O, $time);
    end
    else
    begin
      exp     = expQ.pop_front();
      expKind = (exp.code != ERR_NONE);  // Any error selects errView
      if (DAT_O.charView.kind !== expKind)
        checkField("DAT_O.kind", 8'(expKind), 8'(DAT_O.charView.kind));
      else if (!expKind)
      begin
        checkField("DAT_O.charView.overrun", 8'(exp.overrun), 8'(DAT_O.charView.overrun));
        checkField("DAT_O.charView.reserved", 8'h00, 8'(DAT_O.charView.reserved));
        checkField("DAT_O.charView.data", exp.data, DAT_O.charView.data);
      end
      else
      begin
        checkField("DAT_O.errView.overrun", 8'(exp.overrun), 8'(DAT_O.errView.overrun));
        checkField("DAT_O.errView.code", 8'(exp.code), 8'(DAT_O.errView.code));
        checkField("DAT_O.errView.zero", 8'h00, 8'(DAT_O.errView.zero));
        checkField("DAT_O.errView.data", exp.data, DAT_O.errView.data);  // Raw byte
      end
    end
  endtask

  // Acknowledged transfer
  always @(posedge CLK_I)
  begin
    if (!RST_I && CYC_O && STB_O && ACK_I)
      checkWord();
  end

  // Leftovers at end of run
  task automatic reportMissing();
    expFrame exp;
    while (expQ.size() != 0)
    begin
      exp = expQ.pop_front();
      missingCount++;
      $display("Frame with byte %h and code %s never arrived on the Wishbone port",
               exp.data, exp.code.name());
    end
  endtask

endmodule

`default_nettype wire

// File: test/scReceiver_sva.sv
// ********************
// Wishbone master assertions for the smartcard receiver
// Bound into scReceiver
// ********************
`default_nettype none

module scReceiver_sva (
  input logic        CLK_I,
  input logic        RST_I,
  input logic        CYC_O,
  input logic        STB_O,
  input logic        ACK_I,
  input logic [15:0] DAT_O
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;  // Read by the testbench top

  // Single-transfer cycles
  cycMatchesStb: assert property (@(posedge CLK_I) CYC_O === STB_O)
    else begin failCount++; $error("CYC_O and STB_O differ"); end

  // Word held until acknowledged
  datHeld: assert property (@(posedge CLK_I) disable iff (RST_I)
    (STB_O && !ACK_I) |=> $stable(DAT_O))
    else begin failCount++; $error("DAT_O changed while waiting for ACK_I"); end

  stbDropsAfterAck: assert property (@(posedge CLK_I) disable iff (RST_I)
    (STB_O && ACK_I) |=> !STB_O)
    else begin failCount++; $error("STB_O still high on the clock after ACK_I"); end

  // Bus quiet during reset
  resetQuiet: assert property (@(posedge CLK_I)
    RST_I |=> (!CYC_O && !STB_O && DAT_O == 16'h0000))
    else begin failCount++; $error("Wishbone outputs active during reset"); end

endmodule

bind scReceiver scReceiver_sva u_sva (.*);

`default_nettype wire

// File: source/scReceiver.sv
// ********************
// Smartcard T=0 receiver
// Bit timer, data shifter, frame checker and Wishbone writer
// ********************
`default_nettype none

module scReceiver import scWordPkg::*; (
  input  logic  CLK_I,
  input  logic  RST_I,
  input  logic  ScIo,     // Card I/O line
  input  logic  Ignore,   // Blocks new start edges
  output logic  CYC_O,
  output logic  STB_O,
  input  logic  ACK_I,
  output rxWord DAT_O
);

  charResult shiftResult;
  logic      frameDone;
  rxErrCode  frameErr;

  // Timing broadcast
  scEtuBusIf etuBus ();

  scBitTimer u_bitTimer (
    .CLK_I  (CLK_I),
    .RST_I  (RST_I),
    .ScIo   (ScIo),
    .Ignore (Ignore),
    .bus    (etuBus.timer)
  );

  // Parallel analysis
  scDataShifter u_dataShifter (
    .CLK_I  (CLK_I),
    .RST_I  (RST_I),
    .bus    (etuBus.analyzer),
    .result (shiftResult)
  );

  scFrameChecker u_frameChecker (
    .CLK_I     (CLK_I),
    .RST_I     (RST_I),
    .bus       (etuBus.analyzer),
    .frameDone (frameDone),
    .frameErr  (frameErr)
  );

  scCharWriter u_charWriter (
    .CLK_I     (CLK_I),
    .RST_I     (RST_I),
    .result    (shiftResult),
    .frameDone (frameDone),
    .frameErr  (frameErr),
    .CYC_O     (CYC_O),
    .STB_O     (STB_O),
    .ACK_I     (ACK_I),
    .DAT_O     (DAT_O)
  );

endmodule

`default_nettype wire

// File: source/scCharWriter.sv
// ********************
// Smartcard character writer
// Merges verdicts into a status word, Wishbone classic master
// with sticky overrun flag
// ********************
`default_nettype none

module scCharWriter import scWordPkg::*; (
  input  logic      CLK_I,
  input  logic      RST_I,
  input  charResult result,
  input  logic      frameDone,
  input  rxErrCode  frameErr,
  output logic      CYC_O,
  output logic      STB_O,
  input  logic      ACK_I,
  output rxWord     DAT_O
);

  logic       stb;         // Cycle in progress
  logic       overrun;     // Word dropped since last accepted one
  rxErrCode   mergedErr;
  logic [7:0] byteOut;
  rxWord      nextWord;

  assign CYC_O = stb;  // Single-transfer cycles
  assign STB_O = stb;

  // ********************
  // Verdict merge
  // ********************
  always_comb
  begin
    mergedErr = frameErr;
    if (!result.parityOk)
    begin
      case (frameErr)
        ERR_NONE:  mergedErr = ERR_PARITY;
        ERR_GUARD: mergedErr = ERR_PARITY_GUARD;
        default:   mergedErr = frameErr;  // False start ignores parity
      endcase
    end
  end

  // Word assembly
  always_comb
  begin
    byteOut  = (frameErr == ERR_FALSE_START) ? 8'h00 : result.data;
    nextWord = '0;
    if (mergedErr == ERR_NONE)
    begin
      nextWord.charView.kind     = 1'b0;
      nextWord.charView.overrun  = overrun;
      nextWord.charView.reserved = '0;
      nextWord.charView.data     = byteOut;
    end
    else
    begin
      nextWord.errView.kind    = 1'b1;
      nextWord.errView.overrun = overrun;
      nextWord.errView.code    = mergedErr;
      nextWord.errView.zero    = '0;
      nextWord.errView.data    = byteOut;  // Raw byte
    end
  end

  // ********************
  // Wishbone handshake
  // ********************
  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      stb     <= 1'b0;
      overrun <= 1'b0;
      DAT_O   <= '0;
    end
    else
    begin
      if (stb && ACK_I)
        stb <= 1'b0;  // Drops on the edge after ACK
      if (frameDone)
      begin
        if (stb)
          overrun <= 1'b1;  // Previous word still pending, drop this one
        else
        begin
          DAT_O   <= nextWord;
          stb     <= 1'b1;
          overrun <= 1'b0;  // Reported in this word
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/scFrameChecker.sv
// ********************
// Smartcard frame checker
// Start-bit and guard checks, end-of-frame pulse
// ********************
`default_nettype none

module scFrameChecker import scTimingPkg::*, scWordPkg::*; (
  input  logic     CLK_I,
  input  logic     RST_I,
  scEtuBusIf.analyzer bus,
  output logic     frameDone,
  output rxErrCode frameErr
);

  logic falseStart;    // Sample 0 was high
  logic guardLow;      // Sample 10 was low
  logic startSample;
  logic guardSample;

  assign startSample = bus.sampleStrobe && (bus.sampleIndex == IDX_W'(START_INDEX));
  assign guardSample = bus.sampleStrobe && (bus.sampleIndex == IDX_W'(GUARD_INDEX));

  // ********************
  // Flag capture
  // ********************
  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      frameDone  <= 1'b0;
      falseStart <= 1'b0;
      guardLow   <= 1'b0;
    end
    else
    begin
      // Frame ends at guard, or early on a glitch start
      frameDone <= (startSample && bus.lineLevel) || guardSample;
      if (bus.frameStart)
      begin
        falseStart <= 1'b0;
        guardLow   <= 1'b0;
      end
      if (startSample)
        falseStart <= bus.lineLevel;
      if (guardSample)
        guardLow <= !bus.lineLevel;  // Card holds line low to signal error
    end
  end

  // Framing verdict, false start wins
  always_comb
  begin
    if (falseStart)
      frameErr = ERR_FALSE_START;
    else if (guardLow)
      frameErr = ERR_GUARD;
    else
      frameErr = ERR_NONE;
  end

endmodule

`default_nettype wire

// File: source/scDataShifter.sv
// ********************
// Smartcard data shifter
// Collects the data byte and the even-parity verdict
// ********************
`default_nettype none

module scDataShifter import scTimingPkg::*, scWordPkg::*; (
  input  logic      CLK_I,
  input  logic      RST_I,
  scEtuBusIf.analyzer bus,
  output charResult result
);

  logic [7:0] dataReg;
  logic       parityAcc;     // XOR of data and parity samples
  logic       dataSample;
  logic       paritySample;

  // Samples 1 to 8 carry data
  assign dataSample   = bus.sampleStrobe &&
                        (bus.sampleIndex > IDX_W'(START_INDEX)) &&
                        (bus.sampleIndex < IDX_W'(PARITY_INDEX));
  assign paritySample = bus.sampleStrobe && (bus.sampleIndex == IDX_W'(PARITY_INDEX));

  // Running parity over 9 bits
  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
      parityAcc <= 1'b0;
    else if (bus.frameStart)
      parityAcc <= 1'b0;
    else if (dataSample || paritySample)
      parityAcc <= parityAcc ^ bus.lineLevel;
  end

  // Direct convention, LSB first
  always_ff @(posedge CLK_I)
  begin
    if (bus.frameStart)
      dataReg <= '0;                             // Stays zero on a false start
    else if (dataSample)
      dataReg <= {bus.lineLevel, dataReg[7:1]};  // New bit enters at the top
  end

  // Stable from the clock after the guard strobe
  assign result.data     = dataReg;
  assign result.parityOk = !parityAcc;

endmodule

`default_nettype wire

// File: source/scBitTimer.sv
// ********************
// Smartcard receive bit timer
// Quarter-etu ticks, idle and start detect,
// mid-bit sample strobes for one T=0 frame
// ********************
`default_nettype none

module scBitTimer import scTimingPkg::*; (
  input  logic CLK_I,
  input  logic RST_I,
  input  logic ScIo,
  input  logic Ignore,
  scEtuBusIf.timer bus
);

  logic [1:0]         syncQ;      // Two-flop line synchronizer
  logic               lineSync;
  logic [DIV_W-1:0]   divCnt;     // Clock divider for ticks
  logic               tick;
  logic [1:0]         state;
  logic               sawHigh;    // Previous tick saw the line high
  logic [PHASE_W-1:0] phaseCnt;   // Tick position inside the bit
  logic [PHASE_W-1:0] phaseNext;
  logic [IDX_W-1:0]   bitIdx;     // Next sample index

  assign lineSync  = syncQ[1];
  assign tick      = (divCnt == DIV_W'(QUARTER_ETU_CYCLES - 1));
  assign phaseNext = phaseCnt + 1'b1;  // Wraps once per etu

  // Async line into the clock domain
  always_ff @(posedge CLK_I)
  begin
    syncQ <= {syncQ[0], ScIo};
  end

  // Free-running tick divider
  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
      divCnt <= '0;
    else if (tick)
      divCnt <= '0;
    else
      divCnt <= divCnt + 1'b1;
  end

  // ********************
  // Frame sequencing
  // ********************
  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      state            <= ST_WAIT_IDLE;
      sawHigh          <= 1'b0;
      phaseCnt         <= '0;
      bitIdx           <= '0;
      bus.sampleStrobe <= 1'b0;
      bus.frameStart   <= 1'b0;
    end
    else
    begin
      bus.sampleStrobe <= 1'b0;  // Pulses by default
      bus.frameStart   <= 1'b0;
      if (tick)
      begin
        case (state)
          ST_WAIT_IDLE:
          begin
            sawHigh <= lineSync;
            if (lineSync && sawHigh)
              state <= ST_WAIT_START;  // Two high ticks in a row
          end
          ST_WAIT_START:
          begin
            if (!lineSync)
            begin
              if (Ignore)
              begin
                // Low line under Ignore, rearm idle detect
                state   <= ST_WAIT_IDLE;
                sawHigh <= 1'b0;
              end
              else
              begin
                state          <= ST_SAMPLING;
                bus.frameStart <= 1'b1;
                phaseCnt       <= '0;   // Start tick is tick 0
                bitIdx         <= '0;
              end
            end
          end
          ST_SAMPLING:
          begin
            phaseCnt <= phaseNext;
            if (phaseNext == PHASE_W'(SAMPLE_PHASE))  // Ticks 2 + 4k
            begin
              bus.sampleStrobe <= 1'b1;
              bus.sampleIndex  <= bitIdx;
              bus.lineLevel    <= lineSync;
              bitIdx           <= bitIdx + 1'b1;
              // Guard sampled, or high start bit means a glitch
              if ((bitIdx == IDX_W'(START_INDEX) && lineSync) ||
                  bitIdx == IDX_W'(GUARD_INDEX))
              begin
                state   <= ST_WAIT_IDLE;
                sawHigh <= 1'b0;
              end
            end
          end
          default:
            state <= ST_WAIT_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/scEtuBusIf.sv
// ********************
// Frame timer broadcast
// Mid-bit strobe with index and level, plus start pulse
// ********************
`default_nettype none

interface scEtuBusIf import scTimingPkg::*; ();

  logic             sampleStrobe;  // One clock per bit middle
  logic [IDX_W-1:0] sampleIndex;   // 0 start, 1..8 data, 9 parity, 10 guard
  logic             lineLevel;     // Synchronized line at the strobe
  logic             frameStart;    // Start edge accepted

  // Bit timer side
  modport timer (
    output sampleStrobe,
    output sampleIndex,
    output lineLevel,
    output frameStart
  );

  // Shifter and checker side
  modport analyzer (
    input sampleStrobe,
    input sampleIndex,
    input lineLevel,
    input frameStart
  );

endinterface

`default_nettype wire

// File: source/scWordPkg.sv
// ********************
// Smartcard receive word definitions
// Error codes, shifter result and the 16-bit status word
// ********************
`default_nettype none

package scWordPkg;

  // Frame verdict, framing and parity combined
  typedef enum logic [2:0] {
    ERR_NONE         = 3'd0,
    ERR_FALSE_START  = 3'd1,
    ERR_PARITY       = 3'd2,
    ERR_GUARD        = 3'd3,
    ERR_PARITY_GUARD = 3'd4
  } rxErrCode;

  // Data shifter output
  typedef struct packed {
    logic [7:0] data;      // LSB first on the line
    logic       parityOk;  // Even count of ones over data and parity
  } charResult;

  // ********************
  // Status word views
  // ********************
  typedef struct packed {
    logic       kind;      // 0 for a good character
    logic       overrun;   // Earlier word lost
    logic [5:0] reserved;
    logic [7:0] data;
  } charViewT;

  typedef struct packed {
    logic       kind;      // 1 for a bad frame
    logic       overrun;
    rxErrCode   code;
    logic [2:0] zero;
    logic [7:0] data;      // Raw byte as sampled
  } errViewT;

  // Same 16 bits, decoded by the kind bit
  typedef union packed {
    charViewT charView;
    errViewT  errView;
  } rxWord;

endpackage

`default_nettype wire

// File: source/scTimingPkg.sv
// ********************
// Smartcard frame timing constants
// Tick rate, sample layout and timer states
// ********************
`default_nettype none

package scTimingPkg;

  // ********************
  // Clock and tick rates
  // ********************
  localparam int QUARTER_ETU_CYCLES = 3;   // Clocks per quarter-etu tick, sim value
  localparam int TICKS_PER_ETU      = 4;
  localparam int SAMPLE_PHASE       = TICKS_PER_ETU / 2;  // Mid-bit tick

  // ********************
  // Frame sample layout
  // ********************
  localparam int SAMPLE_COUNT = 11;        // Start, 8 data, parity, guard
  localparam int START_INDEX  = 0;
  localparam int PARITY_INDEX = 9;
  localparam int GUARD_INDEX  = 10;

  // Counter widths
  localparam int DIV_W   = (QUARTER_ETU_CYCLES > 1) ? $clog2(QUARTER_ETU_CYCLES) : 1;
  localparam int PHASE_W = $clog2(TICKS_PER_ETU);
  localparam int IDX_W   = $clog2(SAMPLE_COUNT);

  // Bit timer states
  localparam logic [1:0] ST_WAIT_IDLE  = 2'd0;  // Hunting for two high ticks
  localparam logic [1:0] ST_WAIT_START = 2'd1;  // Armed, waiting for low line
  localparam logic [1:0] ST_SAMPLING   = 2'd2;  // Inside a frame

endpackage

`default_nettype wire
